// ==== common/nn_defines.svh ====
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

// layer geometry
`define NN_NUM_INPUTS 15
`define NN_NUM_NEURONS 4

// activations, weights and sums all share this width
`define NN_DATA_WIDTH 16

`endif

// ==== hiddenLayer/layerWeights.svh ====
`ifndef LAYER_WEIGHTS_SVH
`define LAYER_WEIGHTS_SVH

// row per neuron, inputs 0..14 left to right
`define LAYER_WEIGHTS \
'{ \
	'{-450, 244, 295, -37, -212, 183, 249, -177, \
		-16, -502, 121, 311, -336, -112, -475}, \
	'{312, -88, 57, 406, -251, -19, 140, 233, \
		-367, 92, 18, -143, 275, 61, -204}, \
	'{-73, 158, -290, 14, 337, -126, -58, 401, \
		209, -315, 76, -22, 163, -388, 45}, \
	'{187, 266, -149, -241, 38, 352, -97, -12, \
		128, 71, -433, 254, -66, 199, 307} \
}

// bias per neuron
`define LAYER_BIASES \
'{ \
	0, -1200, 850, -300 \
}

`endif

// ==== common/nnPkg.sv ====
`default_nettype none

`include "nn_defines.svh"

package nnPkg;

	typedef logic signed [`NN_DATA_WIDTH-1:0] activation_t;

	typedef logic [$clog2(`NN_NUM_NEURONS)-1:0] neuronIndex_t;
	typedef logic [$clog2(`NN_NUM_INPUTS)-1:0] inputIndex_t;

	typedef activation_t [`NN_NUM_INPUTS-1:0] featureVector_t; // slot 0 in the low bits
	typedef activation_t [`NN_NUM_NEURONS-1:0] layerResult_t;

	// one output beat
	typedef struct packed
	{
		neuronIndex_t neuron;
		activation_t value;
	} resultBeat_t;

	typedef enum logic
	{
		serIdle,
		serSending
	} serialState_t;

endpackage

`default_nettype wire

// ==== hiddenLayer/neuronRelu.sv ====
`default_nettype none

`include "nn_defines.svh"

module neuronRelu
	import nnPkg::*;
#(
	parameter featureVector_t WEIGHTS = '0,
	parameter activation_t BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input logic advance,
	input featureVector_t features,
	output activation_t activation
);

	featureVector_t featCapture;
	activation_t sumReg;
	activation_t sumNext;

	// low 16 bits of each product, wrapping accumulate
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			sumNext = sumNext + activation_t'(activation_t'(featCapture[i]) * WEIGHTS[i]);
	end

	// ##############################
	// three stages, all held while advance is low
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featCapture <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else if (advance)
		begin
			featCapture <= features;                      // stage 1
			sumReg <= sumNext;                            // stage 2
			activation <= sumReg[`NN_DATA_WIDTH-1] ? '0 : sumReg; // stage 3, relu
		end
	end

	// relu output stays non-negative whatever the weights do
	activationNonNegative: assert property (
		@(posedge clk) disable iff (reset)
		!activation[`NN_DATA_WIDTH-1]
	);

endmodule

`default_nettype wire

// ==== hiddenLayer/hiddenLayer.sv ====
`default_nettype none

`include "nn_defines.svh"
`include "layerWeights.svh"

module hiddenLayer
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic vecValid,
	output logic vecReady,
	input featureVector_t vecData,
	output logic resValid,
	input logic resReady,
	output layerResult_t resData
);

	localparam activation_t weightTable [`NN_NUM_NEURONS][`NN_NUM_INPUTS] = `LAYER_WEIGHTS;
	localparam activation_t biasTable [`NN_NUM_NEURONS] = `LAYER_BIASES;

	logic [2:0] stageValid;
	logic advance;
	activation_t neuronOut [`NN_NUM_NEURONS];

	function automatic featureVector_t weightRow(input int n);
		featureVector_t row;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			row[i] = weightTable[n][i];
		return row;
	endfunction

	// whole pipeline moves only if the last stage can drain
	assign advance = !stageValid[2] || resReady;
	assign vecReady = advance;
	assign resValid = stageValid[2];

	always_ff @(posedge clk)
	begin
		if (reset)
			stageValid <= '0;
		else if (advance)
			stageValid <= {stageValid[1:0], vecValid};
	end

	// ##############################
	for (genvar n = 0; n < `NN_NUM_NEURONS; n++)
	begin : g_neuron
		neuronRelu #(
			.WEIGHTS(weightRow(n)),
			.BIAS(biasTable[n])
		) i_neuron (
			.clk(clk),
			.reset(reset),
			.advance(advance),
			.features(vecData),
			.activation(neuronOut[n])
		);
	end

	always_comb
	begin
		for (int n = 0; n < `NN_NUM_NEURONS; n++)
			resData[n] = neuronOut[n];
	end

	// a stalled result must not change under the serializer
	resultHeldOnStall: assert property (
		@(posedge clk) disable iff (reset)
		resValid && !resReady |=> $stable(resData)
	);

endmodule

`default_nettype wire

// ==== source/featureLoader.sv ====
`default_nettype none

`include "nn_defines.svh"

module featureLoader
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input activation_t inData,
	output logic vecValid,
	input logic vecReady,
	output featureVector_t vecData
);

	localparam inputIndex_t lastIndex = inputIndex_t'(`NN_NUM_INPUTS - 1);

	inputIndex_t slotIndex;
	logic inFire;
	logic vecFire;

	assign inReady = !vecValid; // blocked while a full vector waits
	assign inFire = inValid && inReady;
	assign vecFire = vecValid && vecReady;

	// ##############################
	// slot counter and full flag
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slotIndex <= '0;
			vecValid <= 1'b0;
		end
		else
		begin
			if (inFire)
			begin
				if (slotIndex == lastIndex)
				begin
					slotIndex <= '0;
					vecValid <= 1'b1;
				end
				else
					slotIndex <= slotIndex + 1'b1;
			end
			if (vecFire)
				vecValid <= 1'b0;
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (inFire)
			vecData[slotIndex] <= inData;
	end

	slotInRange: assert property (
		@(posedge clk) disable iff (reset)
		slotIndex <= lastIndex
	);

endmodule

`default_nettype wire

// ==== source/resultSerializer.sv ====
`default_nettype none

`include "nn_defines.svh"

module resultSerializer
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic resValid,
	output logic resReady,
	input layerResult_t resData,
	output logic outValid,
	input logic outReady,
	output resultBeat_t outBeat
);

	localparam neuronIndex_t lastNeuron = neuronIndex_t'(`NN_NUM_NEURONS - 1);

	serialState_t state;
	layerResult_t resultBuf;
	neuronIndex_t beatIndex;

	assign resReady = (state == serIdle);
	assign outValid = (state == serSending);
	assign outBeat.neuron = beatIndex;
	assign outBeat.value = resultBuf[beatIndex];

	// ##############################
	// control
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= serIdle;
			beatIndex <= '0;
		end
		else
		begin
			case (state)
				serIdle:
				begin
					if (resValid)
						state <= serSending;
				end
				serSending:
				begin
					if (outReady)
					begin
						beatIndex <= beatIndex + 1'b1; // wraps back to 0 after the last
						if (beatIndex == lastNeuron)
							state <= serIdle;
					end
				end
				default:
					state <= serIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (resValid && resReady)
			resultBuf <= resData;
	end

	// every result starts at neuron 0
	idleAtZero: assert property (
		@(posedge clk) disable iff (reset)
		state == serIdle |-> beatIndex == '0
	);

endmodule

`default_nettype wire

// ==== source/mlpLayerTop.sv ====
`default_nettype none

module mlpLayerTop
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input activation_t inData,
	output logic outValid,
	input logic outReady,
	output resultBeat_t outBeat
);

	logic vecValid;
	logic vecReady;
	featureVector_t vecData;
	logic resValid;
	logic resReady;
	layerResult_t resData;

	featureLoader i_featureLoader (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.vecValid(vecValid),
		.vecReady(vecReady),
		.vecData(vecData)
	);

	hiddenLayer i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.vecValid(vecValid),
		.vecReady(vecReady),
		.vecData(vecData),
		.resValid(resValid),
		.resReady(resReady),
		.resData(resData)
	);

	resultSerializer i_resultSerializer (
		.clk(clk),
		.reset(reset),
		.resValid(resValid),
		.resReady(resReady),
		.resData(resData),
		.outValid(outValid),
		.outReady(outReady),
		.outBeat(outBeat)
	);

endmodule

`default_nettype wire

// ==== tb/layerModel.svh ====
`ifndef LAYER_MODEL_SVH
`define LAYER_MODEL_SVH

`include "layerWeights.svh"

localparam int modelWeights [`NN_NUM_NEURONS][`NN_NUM_INPUTS] = `LAYER_WEIGHTS;
localparam int modelBiases [`NN_NUM_NEURONS] = `LAYER_BIASES;

// exact integer dot product, only its low 16 bits survive
function automatic layerResult_t expectedLayer(input featureVector_t vec);
	layerResult_t result;
	int acc;
	for (int n = 0; n < `NN_NUM_NEURONS; n++)
	begin
		acc = modelBiases[n];
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			acc += int'(vec[i]) * modelWeights[n][i];
		// bit 15 of the wrapped sum is its sign
		if (acc[`NN_DATA_WIDTH-1])
			result[n] = activation_t'(0);
		else
			result[n] = activation_t'(acc);
	end
	return result;
endfunction

`endif

// ==== tb/mlpLayerTb.sv ====
`default_nettype none

`include "nn_defines.svh"

module mlpLayerTb
	import nnPkg::*;
();

	localparam int numVectors = 26; // 6 directed plus 20 streamed
	localparam int watchdogCycles = 40 * numVectors + 200;

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	logic inReady;
	activation_t inData;
	logic outValid;
	logic outReady;
	resultBeat_t outBeat;

	layerResult_t expectQ [$];
	resultBeat_t expectBeat = '0;
	logic expectPresent = 1'b0;
	int beatCount = 0;
	int beatsChecked = 0;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsAtStart = 0;
	int beatsAtStart = 0;
	int vectorsSent = 0;
	int streamTarget = 0;
	int patternIndex = 0;
	string testName = "reset";
	int unsigned lcgState = 4;
	featureVector_t streamVecs [20];
	logic readyPattern [256];

	`include "layerModel.svh"

	always #5 clk = ~clk;

	mlpLayerTop i_dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.outValid(outValid),
		.outReady(outReady),
		.outBeat(outBeat)
	);

	function automatic int unsigned lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic featureVector_t rampVector(input int start, input int step);
		featureVector_t vec;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			vec[i] = activation_t'(start + i * step); // wraps on purpose
		return vec;
	endfunction

	task automatic reportFailure(input string msg);
		errorCount++;
		$display("%s", msg);
	endtask

	// inReady only moves after a rising edge, so it is stable here
	task automatic sendVector(input featureVector_t vec);
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			inValid = 1'b1;
			inData = vec[i];
			while (!inReady)
				@(negedge clk);
			@(negedge clk);
		end
		inValid = 1'b0;
		expectQ.push_back(expectedLayer(vec));
		vectorsSent++;
	endtask

	task automatic drainResults();
		while (expectQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errorCount;
		beatsAtStart = beatsChecked;
	endtask

	task automatic finishTest();
		int errs;
		errs = errorCount - errorsAtStart;
		testsRun++;
		if (errs != 0)
			testsFailed++;
		$display("%s: %0d beats checked, %0d errors", testName,
			beatsChecked - beatsAtStart, errs);
	endtask

	// ##############################
	// expected beat from the scoreboard front
	always @(posedge clk)
	begin
		if (reset)
			beatCount = 0;
		else if (outValid && outReady)
		begin
			beatsChecked++;
			if (beatCount == `NN_NUM_NEURONS - 1)
			begin
				beatCount = 0;
				if (expectQ.size() != 0)
					void'(expectQ.pop_front());
			end
			else
				beatCount++;
		end
		expectPresent = (expectQ.size() != 0);
		expectBeat.neuron = neuronIndex_t'(beatCount);
		expectBeat.value = expectPresent ? expectQ[0][beatCount] : '0;
	end

	resetState: assert property (@(posedge clk) $fell(reset) |-> !outValid && inReady)
		else reportFailure("outValid or inReady has the wrong level right after reset");

	beatExpected: assert property (@(posedge clk) disable iff (reset)
		outValid |-> expectPresent)
		else reportFailure({"output beat appeared with no result pending in ", testName});

	beatMatches: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady && expectPresent |-> outBeat == expectBeat)
		else reportFailure($sformatf(
			"Mismatch in %s: expected neuron %0d value %0d, actual neuron %0d value %0d",
			testName, $sampled(expectBeat.neuron), $sampled(expectBeat.value),
			$sampled(outBeat.neuron), $sampled(outBeat.value)));

	neverNegative: assert property (@(posedge clk) disable iff (reset)
		outValid |-> !outBeat.value[`NN_DATA_WIDTH-1])
		else reportFailure({"negative output value after relu in ", testName});

	// ##############################
	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		startTest("resetState");
		@(negedge clk);
		finishTest();

		startTest("basicVector");
		sendVector(rampVector(1, 2));
		drainResults();
		finishTest();

		startTest("reluClamp");
		sendVector(rampVector(1, 0)); // neurons 0 and 1 go negative
		sendVector(rampVector(-1, 0)); // neurons 1 and 3 go negative
		drainResults();
		finishTest();

		startTest("wrapAround");
		sendVector(rampVector(32767, 0));
		sendVector(rampVector(-32768, 0));
		sendVector(rampVector(30000, 12345));
		drainResults();
		finishTest();

		startTest("streamStall");
		for (int v = 0; v < 20; v++)
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
				streamVecs[v][i] = activation_t'(lcgNext() >> 16);
		for (int k = 0; k < 256; k++)
			readyPattern[k] = (lcgNext() >> 30) != 0; // ready about 3 beats in 4
		streamTarget = vectorsSent + 20;
		fork
			begin
				for (int v = 0; v < 20; v++)
					sendVector(streamVecs[v]);
			end
			begin
				while (vectorsSent < streamTarget || expectQ.size() != 0)
				begin
					outReady = readyPattern[patternIndex % 256];
					patternIndex++;
					@(negedge clk);
				end
				outReady = 1'b1;
			end
		join
		finishTest();

		repeat (10) @(negedge clk); // stray beats still hit beatExpected
		$display("tests %0d, failed %0d, beats %0d, errors %0d",
			testsRun, testsFailed, beatsChecked, errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout, run still busy after %0d cycles", watchdogCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common/
+incdir+hiddenLayer/
+incdir+tb/
common/nnPkg.sv
hiddenLayer/neuronRelu.sv
hiddenLayer/hiddenLayer.sv
source/featureLoader.sv
source/resultSerializer.sv
source/mlpLayerTop.sv
tb/mlpLayerTb.sv
